/* files.f */
source/clock_pkg.sv
source/button_edge.sv
source/mode_ctrl.sv
source/clock_watch.sv
source/cook_timer.sv
source/fnd_scan.sv
source/multi_watch_top.sv
dv/multi_watch_props.sv
dv/multi_watch_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the watch testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module multi_watch_tb \
    -f files.f \
    -o multi_watch_sim

./obj_dir/multi_watch_sim

/* dv/multi_watch_tb.sv */
`timescale 1ns/1ps

module multi_watch_tb;

    localparam int TPS        = 400;
    localparam int CLK_PERIOD = 40;
    localparam int WAIT_SECS  = 5;
    localparam int STAY_SECS  = 3;
    localparam int PRESS_CYC  = 24;
    // reset, free run, set mode, mode switch, longest countdown of 10:10
    localparam int BUDGET_CYC = 300 + (WAIT_SECS + 3) * TPS
        + 22 * PRESS_CYC + 5 * TPS
        + 2 * PRESS_CYC + (STAY_SECS + 4) * TPS
        + 23 * PRESS_CYC + (10 * 61 + 4) * TPS;
    localparam longint WATCHDOG_NS = 2 * longint'(BUDGET_CYC) * CLK_PERIOD;

    logic            clk = 1'b0;
    logic            reset_p;
    logic [3:0]      button;
    logic            slide;
    clock_pkg::seg_t seg;
    logic [3:0]      com;
    logic [15:0]     led;
    logic            buz;
    // decoded digits, 3 is tens of minutes, 15 means blank
    int              shown_digit [4];
    int              p_sec;
    int              p_min;
    int              v_ref;
    int              v_now;
    int              secs;
    time             t_ref;

    multi_watch_top #(.TICKS_PER_SEC(TPS), .DEBOUNCE_TICKS(4), .SCAN_TICKS(2)) dut0 (
        .clk(clk), .reset_p(reset_p), .button(button), .slide(slide),
        .seg(seg), .com(com), .led(led), .buz(buz));

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////
    // failure reporting and display decoding
    ////////////////////////////////////////////////////////////

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1);
    endtask

    // display values shown as mmss
    task automatic report_diff(input string name, input int expected, input int actual);
        fail_run($sformatf("MISMATCH %s expected %04d actual %04d", name, expected, actual));
    endtask

    function automatic int digit_of_seg(input clock_pkg::seg_t pattern);
        for (int d = 0; d < 10; d++) begin
            if (clock_pkg::seg_of_digit(4'(d)) == pattern) begin
                return d;
            end
        end
        return 15;
    endfunction

    function automatic int shown_value();
        return shown_digit[3] * 1000 + shown_digit[2] * 100
            + shown_digit[1] * 10 + shown_digit[0];
    endfunction

    // add n seconds to an mmss value, hour wrap
    function automatic int add_secs(input int mmss, input int n);
        int total;
        total = ((mmss / 100) * 60 + mmss % 100 + n + 3600) % 3600;
        return (total / 60) * 100 + total % 60;
    endfunction

    // seg and com sampled like a flop, one digit per edge
    always @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (reset_p) begin
                shown_digit[i] <= 15;
            end else if (!com[i]) begin
                shown_digit[i] <= digit_of_seg(seg);
            end
        end
    end

    // hold 12 cycles, release 12 cycles, ends on a falling edge
    task automatic press(input int idx, input int times);
        repeat (times) begin
            @(posedge clk);
            #2 button[idx] = 1'b1;
            repeat (12) @(posedge clk);
            #2 button[idx] = 1'b0;
            repeat (12) @(negedge clk);
        end
    endtask

    // value held over a full scan and not equal to avoid
    task automatic settle(input int avoid, input int limit, output int value);
        int held;
        held = 0;
        value = -1;
        for (int n = 0; n < limit && held < 9; n++) begin
            @(negedge clk);
            held = (shown_value() == value && value != avoid) ? held + 1 : 0;
            value = shown_value();
        end
        assert (held >= 9) else fail_run("display did not settle on a new value in time");
    endtask

    task automatic expect_display(input string name, input int expected, input int limit);
        int held;
        held = 0;
        for (int n = 0; n < limit && held < 9; n++) begin
            @(negedge clk);
            held = (shown_value() == expected) ? held + 1 : 0;
        end
        assert (held >= 9) else report_diff(name, expected, shown_value());
    endtask

    initial begin
        #(WATCHDOG_NS);
        fail_run("watchdog expired before the tests finished");
    end

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(71));
        reset_p = 1'b1;
        button  = '0;
        slide   = 1'b0;
        repeat (5) @(posedge clk);
        #2 reset_p = 1'b0;

        // reset state, watch mode at 00:00, unused leds dark
        expect_display("reset_display", 0, 100);
        assert (led == 16'h0001) else report_diff("reset_led", 1, int'(led));
        assert (!led[15]) else report_diff("reset_alarm", 0, int'(led[15]));

        // free run, align to a tick then check mid-second
        settle(-1, 100, v_ref);
        settle(v_ref, TPS + 100, v_ref);
        repeat (WAIT_SECS * TPS + TPS / 2) @(negedge clk);
        expect_display("watch_run", add_secs(v_ref, WAIT_SECS), 60);

        // set mode, no carry between fields
        press(0, 1);
        settle(-1, 100, v_ref);
        p_sec = 1 + $urandom % 10;
        p_min = 1 + $urandom % 10;
        press(1, p_sec);
        press(2, p_min);
        v_ref = ((v_ref / 100 + p_min) % 60) * 100 + (v_ref % 100 + p_sec) % 60;
        expect_display("watch_set", v_ref, 60);
        repeat (2 * TPS) @(negedge clk);
        expect_display("watch_frozen", v_ref, 20);
        press(0, 1);
        expect_display("watch_resume", add_secs(v_ref, 1), TPS + 100);

        // cook mode, watch keeps counting behind it
        settle(-1, 100, v_ref);
        settle(v_ref, TPS + 100, v_ref);
        t_ref = $time;
        press(3, 1);
        assert (led[1:0] == 2'b10) else report_diff("cook_led", 2, int'(led[1:0]));
        expect_display("cook_display", 0, 60);
        repeat (STAY_SECS * TPS) @(negedge clk);
        press(3, 1);
        assert (led[1:0] == 2'b01) else report_diff("watch_led", 1, int'(led[1:0]));
        settle(-1, 100, v_now);
        settle(v_now, TPS + 100, v_now);
        secs = int'(($time - t_ref) / CLK_PERIOD + TPS / 2) / TPS;
        assert (v_now == add_secs(v_ref, secs))
            else report_diff("watch_background", add_secs(v_ref, secs), v_now);

        // countdown to the alarm, slide switch clears it
        press(3, 1);
        expect_display("cook_clear", 0, 60);
        p_sec = 1 + $urandom % 10;
        p_min = 1 + $urandom % 10;
        press(1, p_sec);
        press(2, p_min);
        v_ref = p_min * 100 + p_sec;
        expect_display("cook_set", v_ref, 60);
        t_ref = $time;
        press(0, 1);
        expect_display("cook_count", add_secs(v_ref, -1), TPS + 100);
        for (int n = 0; n < (p_min * 60 + p_sec + 2) * TPS && !led[15]; n++) begin
            @(negedge clk);
        end
        assert (led[15]) else fail_run("alarm did not rise at the end of the countdown");
        secs = int'(($time - t_ref) / CLK_PERIOD + TPS / 2) / TPS;
        assert (secs == p_min * 60 + p_sec)
            else report_diff("cook_duration", p_min * 60 + p_sec, secs);
        expect_display("cook_zero", 0, 60);
        repeat (100) @(negedge clk);
        assert (led[15] && buz) else report_diff("alarm_hold", 1, int'(led[15] & buz));
        @(posedge clk);
        #2 slide = 1'b1;
        repeat (3) @(negedge clk);
        assert (!led[15]) else report_diff("alarm_off", 0, int'(led[15]));
        @(posedge clk);
        #2 slide = 1'b0;

        $display("All tests passed!");
        $finish;
    end

endmodule

/* dv/multi_watch_props.sv */
`timescale 1ns/1ps

module multi_watch_props (
    input logic        clk,
    input logic        reset_p,
    input logic [3:0]  com,
    input logic [15:0] led,
    input logic        buz,
    input logic        slide,
    input logic [3:0]  btn_pedge
);

    // high from the first edge after reset, once com is driven
    logic scan_live;

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            scan_live <= 1'b0;
        end else begin
            scan_live <= 1'b1;
        end
    end

    // exactly one digit enable low
    com_one_low: assert property (@(posedge clk) disable iff (reset_p)
        scan_live |-> $onehot(~com))
        else $error("com is not one-hot low: %b", com);

    // mode leds one-hot, flipping only after a mode button event
    led_mode: assert property (@(posedge clk) disable iff (reset_p)
        $onehot(led[1:0])
        && (led[1:0] == ($past(btn_pedge[3]) ? ~$past(led[1:0]) : $past(led[1:0]))))
        else $error("mode leds %b did not follow the mode button", led[1:0]);

    // slide switch silences buzzer and alarm led on the next edge
    buz_alarm: assert property (@(posedge clk) disable iff (reset_p)
        slide |=> !buz && !led[15])
        else $error("alarm still on after the slide switch");

endmodule

bind multi_watch_top multi_watch_props props0 (
    .clk(clk), .reset_p(reset_p), .com(com), .led(led), .buz(buz),
    .slide(slide), .btn_pedge(btn_pedge));

/* source/multi_watch_top.sv */
`timescale 1ns/1ps

module multi_watch_top #(
    parameter int unsigned TICKS_PER_SEC  = 50_000_000,
    parameter int unsigned DEBOUNCE_TICKS = 1_000_000,
    parameter int unsigned SCAN_TICKS     = 100_000
) (
    input  logic            clk,
    input  logic            reset_p,
    input  logic [3:0]      button,
    input  logic            slide,
    output clock_pkg::seg_t seg,
    output logic [3:0]      com,
    output logic [15:0]     led,
    output logic            buz
);

    logic [3:0]           btn_pedge;
    clock_pkg::btn_evt_t  watch_evt;
    clock_pkg::btn_evt_t  cook_evt;
    clock_pkg::time_val_t watch_min;
    clock_pkg::time_val_t watch_sec;
    clock_pkg::time_val_t cook_min;
    clock_pkg::time_val_t cook_sec;
    clock_pkg::time_val_t disp_high;
    clock_pkg::time_val_t disp_low;
    clock_pkg::mode_t     mode;
    logic                 alarm;

    button_edge #(.DEBOUNCE_TICKS(DEBOUNCE_TICKS)) btn0 (
        .clk(clk), .reset_p(reset_p), .button(button), .btn_pedge(btn_pedge));

    mode_ctrl mode0 (
        .clk(clk), .reset_p(reset_p), .btn_pedge(btn_pedge),
        .watch_min(watch_min), .watch_sec(watch_sec),
        .cook_min(cook_min), .cook_sec(cook_sec),
        .watch_evt(watch_evt), .cook_evt(cook_evt),
        .disp_high(disp_high), .disp_low(disp_low), .mode(mode));

    clock_watch #(.TICKS_PER_SEC(TICKS_PER_SEC)) watch0 (
        .clk(clk), .reset_p(reset_p), .evt(watch_evt), .min(watch_min), .sec(watch_sec));

    cook_timer #(.TICKS_PER_SEC(TICKS_PER_SEC)) cook0 (
        .clk(clk), .reset_p(reset_p), .evt(cook_evt), .alarm_off(slide),
        .min(cook_min), .sec(cook_sec), .alarm(alarm));

    fnd_scan #(.SCAN_TICKS(SCAN_TICKS)) fnd0 (
        .clk(clk), .reset_p(reset_p), .disp_high(disp_high), .disp_low(disp_low),
        .seg(seg), .com(com));

    // mode leds, alarm on led 15 and the buzzer
    assign led[0]    = (mode == clock_pkg::MODE_WATCH);
    assign led[1]    = (mode == clock_pkg::MODE_COOK);
    assign led[14:2] = '0;
    assign led[15]   = alarm;
    assign buz       = alarm;

endmodule

/* source/fnd_scan.sv */
`timescale 1ns/1ps

module fnd_scan #(
    parameter int unsigned SCAN_TICKS = 100_000
) (
    input  logic                 clk,
    input  logic                 reset_p,
    input  clock_pkg::time_val_t disp_high,
    input  clock_pkg::time_val_t disp_low,
    output clock_pkg::seg_t      seg,
    output logic [3:0]           com
);

    localparam int unsigned SCAN_W = $clog2(SCAN_TICKS + 1);
    localparam logic [SCAN_W-1:0] SCAN_LAST = SCAN_W'(SCAN_TICKS - 1);

    clock_pkg::bcd_pair_t bcd_high;
    clock_pkg::bcd_pair_t bcd_low;
    logic [SCAN_W-1:0]    scan_cnt;
    logic [1:0]           digit_idx;
    logic [3:0]           digit_val;

    assign bcd_high = clock_pkg::to_bcd(disp_high);
    assign bcd_low  = clock_pkg::to_bcd(disp_low);

    // digit 3 is leftmost, tens of minutes
    always_comb begin
        case (digit_idx)
            2'd3:    digit_val = bcd_high[7:4];
            2'd2:    digit_val = bcd_high[3:0];
            2'd1:    digit_val = bcd_low[7:4];
            default: digit_val = bcd_low[3:0];
        endcase
    end

    ////////////////////////////////////////////////////////////
    // scan timing
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            scan_cnt  <= '0;
            digit_idx <= '0;
            com       <= 4'b1111;
        end else begin
            if (scan_cnt == SCAN_LAST) begin
                scan_cnt  <= '0;
                digit_idx <= digit_idx + 2'd1;
            end else begin
                scan_cnt <= scan_cnt + 1'b1;
            end
            // one enable low, registered to line up with seg
            com <= ~(4'b0001 << digit_idx);
        end
    end

    // segment pattern for the digit being enabled
    always_ff @(posedge clk) begin
        seg <= clock_pkg::seg_of_digit(digit_val);
    end

endmodule

/* source/cook_timer.sv */
`timescale 1ns/1ps

module cook_timer #(
    parameter int unsigned TICKS_PER_SEC = 50_000_000
) (
    input  logic                 clk,
    input  logic                 reset_p,
    input  clock_pkg::btn_evt_t  evt,
    input  logic                 alarm_off,
    output clock_pkg::time_val_t min,
    output clock_pkg::time_val_t sec,
    output logic                 alarm
);

    localparam int unsigned TICK_W = $clog2(TICKS_PER_SEC + 1);
    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(TICKS_PER_SEC - 1);

    typedef enum logic {
        IDLE = 1'b0,
        RUN  = 1'b1
    } state_t;

    state_t            state;
    logic [TICK_W-1:0] tick_cnt;
    logic              tick;
    logic              at_zero;

    assign at_zero = (min == '0) && (sec == '0);
    assign tick    = (state == RUN) && (tick_cnt == TICK_LAST);

    // prescaler starts from zero on every start or resume
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            tick_cnt <= '0;
        end else if (state != RUN || tick) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // countdown fsm
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            state <= IDLE;
            min   <= '0;
            sec   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    // nothing to count from 00:00
                    if (evt[0] && !at_zero) begin
                        state <= RUN;
                    end
                    if (evt[1]) begin
                        sec <= (sec == clock_pkg::TIME_MAX) ? '0 : sec + 8'd1;
                    end
                    if (evt[2]) begin
                        min <= (min == clock_pkg::TIME_MAX) ? '0 : min + 8'd1;
                    end
                end
                RUN: begin
                    if (at_zero) begin
                        state <= IDLE;
                    end else if (evt[0]) begin
                        // pause, time is kept
                        state <= IDLE;
                    end else if (tick) begin
                        if (sec == '0) begin
                            // borrow one minute
                            sec <= clock_pkg::TIME_MAX;
                            min <= min - 8'd1;
                        end else begin
                            sec <= sec - 8'd1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // alarm latches at the end of a run, slide switch silences it
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            alarm <= 1'b0;
        end else if (alarm_off) begin
            alarm <= 1'b0;
        end else if (state == RUN && at_zero) begin
            alarm <= 1'b1;
        end
    end

endmodule

/* source/clock_watch.sv */
`timescale 1ns/1ps

module clock_watch #(
    parameter int unsigned TICKS_PER_SEC = 50_000_000
) (
    input  logic                 clk,
    input  logic                 reset_p,
    input  clock_pkg::btn_evt_t  evt,
    output clock_pkg::time_val_t min,
    output clock_pkg::time_val_t sec
);

    localparam int unsigned TICK_W = $clog2(TICKS_PER_SEC + 1);
    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(TICKS_PER_SEC - 1);

    logic              set_mode;
    logic [TICK_W-1:0] tick_cnt;
    logic              tick;

    // one second strobe, never in set mode
    assign tick = !set_mode && (tick_cnt == TICK_LAST);

    // event 0 enters and leaves set mode
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            set_mode <= 1'b0;
        end else if (evt[0]) begin
            set_mode <= ~set_mode;
        end
    end

    // prescaler holds its count while setting
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            tick_cnt <= '0;
        end else if (tick) begin
            tick_cnt <= '0;
        end else if (!set_mode) begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // minutes and seconds
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            min <= '0;
            sec <= '0;
        end else if (set_mode) begin
            // manual adjust, no carry between fields
            if (evt[1]) begin
                sec <= (sec == clock_pkg::TIME_MAX) ? '0 : sec + 8'd1;
            end
            if (evt[2]) begin
                min <= (min == clock_pkg::TIME_MAX) ? '0 : min + 8'd1;
            end
        end else if (tick) begin
            if (sec == clock_pkg::TIME_MAX) begin
                sec <= '0;
                // hour rollover, minutes start again
                min <= (min == clock_pkg::TIME_MAX) ? '0 : min + 8'd1;
            end else begin
                sec <= sec + 8'd1;
            end
        end
    end

endmodule

/* source/mode_ctrl.sv */
`timescale 1ns/1ps

module mode_ctrl (
    input  logic                  clk,
    input  logic                  reset_p,
    input  logic [3:0]            btn_pedge,
    input  clock_pkg::time_val_t  watch_min,
    input  clock_pkg::time_val_t  watch_sec,
    input  clock_pkg::time_val_t  cook_min,
    input  clock_pkg::time_val_t  cook_sec,
    output clock_pkg::btn_evt_t   watch_evt,
    output clock_pkg::btn_evt_t   cook_evt,
    output clock_pkg::time_val_t  disp_high,
    output clock_pkg::time_val_t  disp_low,
    output clock_pkg::mode_t      mode
);

    ////////////////////////////////////////////////////////////
    // mode register
    ////////////////////////////////////////////////////////////

    // button 3 flips between the two functions
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            mode <= clock_pkg::MODE_WATCH;
        end else if (btn_pedge[3]) begin
            if (mode == clock_pkg::MODE_WATCH) begin
                mode <= clock_pkg::MODE_COOK;
            end else begin
                mode <= clock_pkg::MODE_WATCH;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // event routing and display select
    ////////////////////////////////////////////////////////////

    always_comb begin
        // the inactive function sees no events
        watch_evt = '0;
        cook_evt  = '0;
        disp_high = watch_min;
        disp_low  = watch_sec;
        case (mode)
            clock_pkg::MODE_COOK: begin
                cook_evt  = btn_pedge[2:0];
                disp_high = cook_min;
                disp_low  = cook_sec;
            end
            default: begin
                watch_evt = btn_pedge[2:0];
            end
        endcase
    end

endmodule

/* source/button_edge.sv */
`timescale 1ns/1ps

module button_edge #(
    parameter int unsigned DEBOUNCE_TICKS = 1_000_000
) (
    input  logic       clk,
    input  logic       reset_p,
    input  logic [3:0] button,
    output logic [3:0] btn_pedge
);

    localparam int unsigned CNT_W = $clog2(DEBOUNCE_TICKS + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_TICKS - 1);

    // two flop synchronizer per button
    logic [3:0] sync_1;
    logic [3:0] sync_2;
    // debounced level per button
    logic [3:0] level;
    // one counter shared by all four buttons
    logic [CNT_W-1:0] stable_cnt;

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            sync_1     <= '0;
            sync_2     <= '0;
            level      <= '0;
            stable_cnt <= '0;
            btn_pedge  <= '0;
        end else begin
            sync_1    <= button;
            sync_2    <= sync_1;
            btn_pedge <= '0;
            // restart when the input is about to move or nothing differs
            if (sync_1 != sync_2 || sync_2 == level) begin
                stable_cnt <= '0;
            end else if (stable_cnt == CNT_LAST) begin
                stable_cnt <= '0;
                level      <= sync_2;
                // rising edges only, release gives no pulse
                btn_pedge  <= sync_2 & ~level;
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

endmodule

/* source/clock_pkg.sv */
package clock_pkg;

    ////////////////////////////////////////////////////////////
    // shared types
    ////////////////////////////////////////////////////////////

    // minute or second value, 0 to 59
    typedef logic [7:0] time_val_t;

    // tens digit in [7:4], units digit in [3:0]
    typedef logic [7:0] bcd_pair_t;

    // bit 0 start or set, bit 1 plus one second, bit 2 plus one minute
    typedef logic [2:0] btn_evt_t;

    // active low, {dp, g, f, e, d, c, b, a}
    typedef logic [7:0] seg_t;

    // display and button owner
    typedef enum logic [1:0] {
        MODE_WATCH = 2'd0,
        MODE_COOK  = 2'd1
    } mode_t;

    // top value for both seconds and minutes
    localparam time_val_t TIME_MAX = 8'd59;

    ////////////////////////////////////////////////////////////
    // conversion helpers
    ////////////////////////////////////////////////////////////

    // split a 0..59 value into two bcd digits
    function automatic bcd_pair_t to_bcd(input time_val_t value);
        logic [3:0] tens;
        logic [3:0] units;
        tens  = 4'(value / 8'd10);
        units = 4'(value % 8'd10);
        return {tens, units};
    endfunction

    // segment pattern for one decimal digit, dp always dark
    function automatic seg_t seg_of_digit(input logic [3:0] digit);
        case (digit)
            4'd0:    return 8'hC0;
            4'd1:    return 8'hF9;
            4'd2:    return 8'hA4;
            4'd3:    return 8'hB0;
            4'd4:    return 8'h99;
            4'd5:    return 8'h92;
            4'd6:    return 8'h82;
            4'd7:    return 8'hF8;
            4'd8:    return 8'h80;
            4'd9:    return 8'h90;
            // blank for anything not decimal
            default: return 8'hFF;
        endcase
    endfunction

endpackage
